// ==== flist.f ====
+incdir+tests
src/cache_types_pkg.sv
src/cache_line_store.sv
src/cache_mshr_buffer.sv
src/cache_bank_dispatch.sv
src/cache_refill_bank.sv
src/nonblocking_cache.sv
tests/tb_nonblocking_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        -f flist.f --top-module tb_nonblocking_cache -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_nonblocking_cache
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi

exit 0

// ==== src/cache_bank_dispatch.sv ====
`timescale 1ns/1ps

module cache_bank_dispatch (
    input  logic                              CLK,
    input  logic                              nRST,
    input  cache_types_pkg::mshr_reg          mshr_out,
    input  logic [cache_types_pkg::BANKS-1:0] bank_busy,
    output logic                              bank_free,
    output logic [cache_types_pkg::BANKS-1:0] start,
    output cache_types_pkg::mshr_reg          start_entry
);
    cache_types_pkg::cache_addr            head_addr;
    logic [cache_types_pkg::BANKS_LEN-1:0] head_bank;
    logic [cache_types_pkg::BANKS_LEN-1:0] slot_bank;
    logic                                  slot_valid;
    cache_types_pkg::mshr_reg              slot_entry;

    assign head_addr = mshr_out.block_addr;
    assign head_bank = head_addr.index[cache_types_pkg::BANKS_LEN-1:0];

    // a block always refills on the same bank, which keeps refills of one set in order
    assign bank_free = mshr_out.valid && !slot_valid && !bank_busy[head_bank];

    // ********************************************************************
    // hand-off slot
    // ********************************************************************

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            slot_valid <= 1'b0;
            slot_bank  <= '0;
        end else begin
            slot_valid <= bank_free;  // the idle bank takes it on the next edge
            if (bank_free) begin
                slot_bank <= head_bank;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (bank_free) begin
            slot_entry <= mshr_out;
        end
    end

    always_comb begin
        start            = '0;
        start[slot_bank] = slot_valid;
    end

    assign start_entry = slot_entry;

endmodule

// ==== src/cache_line_store.sv ====
`timescale 1ns/1ps

module cache_line_store (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  logic                                   req_valid,
    input  cache_types_pkg::in_mem_instr           req_instr,
    input  logic                                   accept,
    input  logic [cache_types_pkg::BANKS-1:0]      fill_req,
    input  logic [cache_types_pkg::BANKS-1:0][cache_types_pkg::ADDR_W-1:0] fill_addr,
    input  cache_types_pkg::cache_block [cache_types_pkg::BANKS-1:0] fill_line,
    output logic                                   hit,
    output logic                                   hit_valid,
    output logic [cache_types_pkg::WORD_W-1:0]     hit_data,
    output logic [cache_types_pkg::BANKS-1:0]      fill_ack
);
    logic [cache_types_pkg::NUM_SETS-1:0]    valid_bits;
    logic [cache_types_pkg::TAG_BIT_LEN-1:0] tags [cache_types_pkg::NUM_SETS];
    cache_types_pkg::cache_block             lines [cache_types_pkg::NUM_SETS];

    cache_types_pkg::cache_addr              fill_field;
    logic [cache_types_pkg::BANKS_LEN-1:0]   fill_sel;
    logic                                    fill_any;
    logic                                    load_hit;
    logic                                    store_hit;
    logic                                    store_keep;

    assign hit = req_valid && valid_bits[req_instr.addr.index]
                 && (tags[req_instr.addr.index] == req_instr.addr.tag);

    assign load_hit  = accept && hit && !req_instr.rw_mode;
    assign store_hit = accept && hit && req_instr.rw_mode;

    // fixed priority, lowest bank first
    always_comb begin
        fill_ack = '0;
        fill_sel = '0;
        fill_any = 1'b0;
        for (int b = 0; b < cache_types_pkg::BANKS; b++) begin
            if (fill_req[b] && !fill_any) begin
                fill_ack[b] = 1'b1;
                fill_sel    = b[cache_types_pkg::BANKS_LEN-1:0];
                fill_any    = 1'b1;
            end
        end
    end

    assign fill_field = fill_addr[fill_sel];

    // a store hit is lost only if the fill replaces that set with another block
    assign store_keep = store_hit
                        && (!fill_any || fill_field.index != req_instr.addr.index
                            || fill_field.tag == req_instr.addr.tag);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_bits <= '0;
            hit_valid  <= 1'b0;
        end else begin
            hit_valid <= load_hit;
            if (fill_any) begin
                valid_bits[fill_field.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_any) begin
            tags[fill_field.index]  <= fill_field.tag;
            lines[fill_field.index] <= fill_line[fill_sel];
        end
        if (store_keep) begin  // later assignment wins over the fill word
            lines[req_instr.addr.index][req_instr.addr.block_offset] <= req_instr.store_value;
        end
        if (load_hit) begin
            hit_data <= lines[req_instr.addr.index][req_instr.addr.block_offset];
        end
    end

endmodule

// ==== src/cache_mshr_buffer.sv ====
`timescale 1ns/1ps

module cache_mshr_buffer (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic                                  miss,
    input  cache_types_pkg::in_mem_instr          mem_instr,
    input  logic                                  bank_free,
    output cache_types_pkg::mshr_reg              mshr_out,
    output logic                                  stall,
    output logic [cache_types_pkg::UUID_SIZE-1:0] uuid_out,
    output logic                                  buffer_empty
);
    cache_types_pkg::mshr_reg [cache_types_pkg::MSHR_BUFFER_LEN-1:0] buffer;
    cache_types_pkg::mshr_reg [cache_types_pkg::MSHR_BUFFER_LEN-1:0] next_buffer;
    cache_types_pkg::mshr_reg                                        new_entry;

    logic [cache_types_pkg::UUID_SIZE-1:0]           uuid, next_uuid;
    logic [cache_types_pkg::MSHR_BUFFER_BIT_LEN-1:0] lptr, rptr, next_lptr, next_rptr;
    logic [cache_types_pkg::BLOCK_OFF_BIT_LEN-1:0]   offset;

    logic head_leaving;
    logic full;
    logic merged;

    assign offset       = mem_instr.addr.block_offset;
    assign head_leaving = bank_free && buffer[rptr].valid;
    // the occupied entries run from rptr down to lptr+1
    assign full         = (lptr == rptr) && buffer[rptr].valid;
    assign mshr_out     = buffer[rptr];

    always_comb begin
        new_entry                      = '0;
        new_entry.valid                = 1'b1;
        new_entry.uuid                 = uuid;
        new_entry.block_addr           = {mem_instr.addr.tag, mem_instr.addr.index,
            {(cache_types_pkg::BLOCK_OFF_BIT_LEN + cache_types_pkg::BYTE_OFF_BIT_LEN){1'b0}}};
        new_entry.write_status[offset] = mem_instr.rw_mode;
        new_entry.write_block[offset]  = mem_instr.store_value;
    end

    // ********************************************************************
    // allocation, merging and head release
    // ********************************************************************

    always_comb begin
        next_buffer = buffer;
        next_lptr   = lptr;
        next_rptr   = rptr;
        next_uuid   = uuid;
        uuid_out    = '0;
        stall       = 1'b0;
        merged      = 1'b0;

        // release the head first so that a full buffer can refill its slot
        if (head_leaving) begin
            next_buffer[rptr].valid = 1'b0;
            next_rptr               = rptr - 1'b1;
        end

        if (miss) begin
            for (int i = 0; i < cache_types_pkg::MSHR_BUFFER_LEN; i++) begin
                if (!merged && buffer[i].valid && i != int'(rptr)
                    && buffer[i].block_addr == new_entry.block_addr) begin
                    merged                           = 1'b1;
                    next_buffer[i].uuid              = uuid;  // newest request owns the entry
                    next_buffer[i].write_status[offset] =
                        buffer[i].write_status[offset] | mem_instr.rw_mode;
                    if (mem_instr.rw_mode) begin
                        next_buffer[i].write_block[offset] = mem_instr.store_value;
                    end
                end
            end

            if (!merged) begin
                if (full && !head_leaving) begin
                    stall = 1'b1;
                end else begin
                    next_buffer[lptr] = new_entry;
                    next_lptr         = lptr - 1'b1;
                end
            end

            if (!stall) begin
                uuid_out  = uuid;
                next_uuid = uuid + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            buffer <= '0;
            uuid   <= '0;
            lptr   <= cache_types_pkg::MSHR_BUFFER_BIT_LEN'(cache_types_pkg::MSHR_BUFFER_LEN - 1);
            rptr   <= cache_types_pkg::MSHR_BUFFER_BIT_LEN'(cache_types_pkg::MSHR_BUFFER_LEN - 1);
        end else begin
            buffer <= next_buffer;
            uuid   <= next_uuid;
            lptr   <= next_lptr;
            rptr   <= next_rptr;
        end
    end

    always_comb begin
        buffer_empty = 1'b1;
        for (int j = 0; j < cache_types_pkg::MSHR_BUFFER_LEN; j++) begin
            if (buffer[j].valid) begin
                buffer_empty = 1'b0;
            end
        end
    end

endmodule

// ==== src/cache_refill_bank.sv ====
`timescale 1ns/1ps

module cache_refill_bank (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic                                  start,
    input  cache_types_pkg::mshr_reg              start_entry,
    input  logic                                  mem_rd_valid,
    input  cache_types_pkg::cache_block           mem_rd_data,
    input  logic                                  fill_ack,
    output logic                                  bank_busy,
    output logic                                  mem_rd_req,
    output logic [cache_types_pkg::ADDR_W-1:0]    mem_rd_addr,
    output logic                                  fill_req,
    output logic [cache_types_pkg::ADDR_W-1:0]    fill_addr,
    output cache_types_pkg::cache_block           fill_line,
    output logic                                  done_valid,
    output logic [cache_types_pkg::UUID_SIZE-1:0] done_uuid
);
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        FILL
    } state_t;

    state_t                      state, next_state;
    cache_types_pkg::mshr_reg    entry;
    cache_types_pkg::cache_block line;
    cache_types_pkg::cache_block merged_line;

    // buffered store words take precedence over the memory copy
    always_comb begin
        for (int w = 0; w < cache_types_pkg::BLOCK_WORDS; w++) begin
            merged_line[w] = entry.write_status[w] ? entry.write_block[w] : mem_rd_data[w];
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) begin
                    next_state = FETCH;
                end
            end
            FETCH: begin
                if (mem_rd_valid) begin
                    next_state = FILL;
                end
            end
            FILL: begin
                if (fill_ack) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && start) begin
            entry <= start_entry;
        end
        if (state == FETCH && mem_rd_valid) begin
            line <= merged_line;
        end
    end

    assign bank_busy   = (state != IDLE);
    assign mem_rd_req  = (state == FETCH);
    assign mem_rd_addr = entry.block_addr;
    assign fill_req    = (state == FILL);
    assign fill_addr   = entry.block_addr;
    assign fill_line   = line;

    // completion goes out in the cycle the line store takes the line
    assign done_valid = (state == FILL) && fill_ack;
    assign done_uuid  = entry.uuid;

endmodule

// ==== src/cache_types_pkg.sv ====
package cache_types_pkg;

    // ********************************************************************
    // sizing
    // ********************************************************************

    localparam int WORD_W            = 32;
    localparam int BYTE_OFF_BIT_LEN  = 2;
    localparam int BLOCK_WORDS       = 4;
    localparam int BLOCK_OFF_BIT_LEN = 2;
    localparam int INDEX_BIT_LEN     = 3;
    localparam int TAG_BIT_LEN       = 25;

    // full byte address, 32 bits with the fields above
    localparam int ADDR_W   = TAG_BIT_LEN + INDEX_BIT_LEN + BLOCK_OFF_BIT_LEN + BYTE_OFF_BIT_LEN;
    localparam int NUM_SETS = 1 << INDEX_BIT_LEN;

    localparam int BANKS     = 2;
    localparam int BANKS_LEN = 1;  // bank is picked by the low index bits

    localparam int MSHR_BUFFER_LEN     = 4;
    localparam int MSHR_BUFFER_BIT_LEN = 2;
    localparam int UUID_SIZE           = 8;

    // ********************************************************************
    // types
    // ********************************************************************

    typedef struct packed {
        logic [TAG_BIT_LEN-1:0]       tag;
        logic [INDEX_BIT_LEN-1:0]     index;
        logic [BLOCK_OFF_BIT_LEN-1:0] block_offset;
        logic [BYTE_OFF_BIT_LEN-1:0]  byte_offset;
    } cache_addr;

    // one cache line, word 0 in the low bits
    typedef logic [BLOCK_WORDS-1:0][WORD_W-1:0] cache_block;

    typedef struct packed {
        cache_addr         addr;
        logic              rw_mode;      // 1 for a store
        logic [WORD_W-1:0] store_value;
    } in_mem_instr;

    // one outstanding block miss with the store words collected so far
    typedef struct packed {
        logic                   valid;
        logic [UUID_SIZE-1:0]   uuid;
        logic [ADDR_W-1:0]      block_addr;   // offsets are zero
        logic [BLOCK_WORDS-1:0] write_status; // words that override the refill data
        cache_block             write_block;
    } mshr_reg;

endpackage

// ==== src/nonblocking_cache.sv ====
`timescale 1ns/1ps

module nonblocking_cache (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic                                  req_valid,
    input  logic                                  req_rw,
    input  logic [cache_types_pkg::ADDR_W-1:0]    req_addr,
    input  logic [cache_types_pkg::WORD_W-1:0]    req_store_value,
    input  logic [cache_types_pkg::BANKS-1:0]     mem_rd_valid,
    input  cache_types_pkg::cache_block [cache_types_pkg::BANKS-1:0] mem_rd_data,
    output logic                                  req_ready,
    output logic                                  hit_valid,
    output logic [cache_types_pkg::WORD_W-1:0]    hit_data,
    output logic                                  miss_uuid_valid,
    output logic [cache_types_pkg::UUID_SIZE-1:0] miss_uuid,
    output logic [cache_types_pkg::BANKS-1:0]     done_valid,
    output logic [cache_types_pkg::BANKS-1:0][cache_types_pkg::UUID_SIZE-1:0] done_uuid,
    output logic [cache_types_pkg::BANKS-1:0]     mem_rd_req,
    output logic [cache_types_pkg::BANKS-1:0][cache_types_pkg::ADDR_W-1:0] mem_rd_addr,
    output logic                                  mem_wr_valid,
    output logic [cache_types_pkg::ADDR_W-1:0]    mem_wr_addr,
    output logic [cache_types_pkg::WORD_W-1:0]    mem_wr_data,
    output logic                                  buffer_empty
);
    cache_types_pkg::in_mem_instr                     req_instr;
    cache_types_pkg::mshr_reg                         mshr_out;
    cache_types_pkg::mshr_reg                         start_entry;
    cache_types_pkg::cache_block [cache_types_pkg::BANKS-1:0] fill_line;
    logic [cache_types_pkg::BANKS-1:0][cache_types_pkg::ADDR_W-1:0] fill_addr;
    logic [cache_types_pkg::BANKS-1:0]                fill_req, fill_ack;
    logic [cache_types_pkg::BANKS-1:0]                bank_busy, start;
    logic [cache_types_pkg::UUID_SIZE-1:0]            uuid_out;
    logic hit, miss, stall, accept, bank_free;

    assign req_instr.addr        = req_addr;
    assign req_instr.rw_mode     = req_rw;
    assign req_instr.store_value = req_store_value;

    assign miss      = req_valid && !hit;
    assign req_ready = !stall;  // stall only rises for a miss that finds no room
    assign accept    = req_valid && req_ready;

    assign miss_uuid_valid = miss && !stall;
    assign miss_uuid       = uuid_out;

    // write-through of every accepted store, hit or miss
    assign mem_wr_valid = accept && req_rw;
    assign mem_wr_addr  = req_addr;
    assign mem_wr_data  = req_store_value;

    cache_line_store i_line_store (
        .CLK(CLK), .nRST(nRST), .req_valid(req_valid), .req_instr(req_instr),
        .accept(accept), .fill_req(fill_req), .fill_addr(fill_addr), .fill_line(fill_line),
        .hit(hit), .hit_valid(hit_valid), .hit_data(hit_data), .fill_ack(fill_ack)
    );

    cache_mshr_buffer i_mshr_buffer (
        .CLK(CLK), .nRST(nRST), .miss(miss), .mem_instr(req_instr), .bank_free(bank_free),
        .mshr_out(mshr_out), .stall(stall), .uuid_out(uuid_out), .buffer_empty(buffer_empty)
    );

    cache_bank_dispatch i_bank_dispatch (
        .CLK(CLK), .nRST(nRST), .mshr_out(mshr_out), .bank_busy(bank_busy),
        .bank_free(bank_free), .start(start), .start_entry(start_entry)
    );

    for (genvar b = 0; b < cache_types_pkg::BANKS; b++) begin : g_bank
        cache_refill_bank i_refill_bank (
            .CLK(CLK), .nRST(nRST), .start(start[b]), .start_entry(start_entry),
            .mem_rd_valid(mem_rd_valid[b]), .mem_rd_data(mem_rd_data[b]),
            .fill_ack(fill_ack[b]), .bank_busy(bank_busy[b]),
            .mem_rd_req(mem_rd_req[b]), .mem_rd_addr(mem_rd_addr[b]),
            .fill_req(fill_req[b]), .fill_addr(fill_addr[b]), .fill_line(fill_line[b]),
            .done_valid(done_valid[b]), .done_uuid(done_uuid[b])
        );
    end

endmodule

// ==== tests/tb_cache_model.svh ====
`ifndef TB_CACHE_MODEL_SVH
`define TB_CACHE_MODEL_SVH

// word-addressed copy of backing memory, written by every accepted store
logic [cache_types_pkg::WORD_W-1:0] model_mem [logic [cache_types_pkg::ADDR_W-1:0]];
logic [(1 << cache_types_pkg::UUID_SIZE)-1:0] outstanding = '0;  // issued, not yet completed
logic [cache_types_pkg::UUID_SIZE-1:0]        next_uuid   = '0;

// untouched words read back as a pattern of their own address
function automatic logic [31:0] model_read(input logic [31:0] addr);
    if (model_mem.exists(addr)) begin
        return model_mem[addr];
    end
    return {addr[15:0], addr[31:16]} ^ 32'h6c8e_9cf5;
endfunction

function automatic logic [31:0] block_of(input logic [31:0] addr);
    return {addr[31:4], 4'b0000};
endfunction

function automatic cache_types_pkg::cache_block model_block(input logic [31:0] block_addr);
    cache_types_pkg::cache_block blk;
    for (int w = 0; w < cache_types_pkg::BLOCK_WORDS; w++) begin
        blk[w] = model_read(block_addr + 32'(4 * w));
    end
    return blk;
endfunction

task automatic model_store(input logic [31:0] addr, input logic [31:0] data);
    model_mem[addr] = data;
endtask

task automatic issue_uuid(input logic [cache_types_pkg::UUID_SIZE-1:0] uuid);
    outstanding[uuid] = 1'b1;
    next_uuid = uuid + 1'b1;  // wraps at 256
endtask

task automatic complete_uuid(input logic [cache_types_pkg::UUID_SIZE-1:0] uuid);
    outstanding[uuid] = 1'b0;
endtask

// a miss must complete, after which the same word has to hit
task automatic read_back(input logic [31:0] addr);
    logic [cache_types_pkg::UUID_SIZE-1:0] uuid;
    int n;
    drive(1'b1, 1'b0, addr, '0);
    assert (req_ready) else report_error($sformatf("read-back of 0x%0h was stalled", addr));
    if (miss_uuid_valid) begin
        uuid = miss_uuid;
        for (n = 0; n < 200 && outstanding[uuid]; n++) begin
            drive(1'b0, 1'b0, '0, '0);
        end
        assert (!outstanding[uuid])
            else report_error($sformatf("timeout waiting for uuid 0x%0h to complete", uuid));
    end
    drive(1'b1, 1'b0, addr, '0);
    assert (!miss_uuid_valid)
        else report_error($sformatf("repeated read of 0x%0h missed again", addr));
    drive(1'b0, 1'b0, '0, '0);  // hit data of the second read is checked here
endtask

`endif

// ==== tests/tb_nonblocking_cache.sv ====
`timescale 1ns/1ps

module tb_nonblocking_cache;

    logic                                      CLK = 1'b0;
    logic                                      nRST;
    logic                                      req_valid, req_rw;
    logic [cache_types_pkg::ADDR_W-1:0]        req_addr, mem_wr_addr;
    logic [cache_types_pkg::WORD_W-1:0]        req_store_value, hit_data, mem_wr_data;
    logic [cache_types_pkg::BANKS-1:0]         mem_rd_valid, done_valid, mem_rd_req;
    cache_types_pkg::cache_block [cache_types_pkg::BANKS-1:0] mem_rd_data;
    logic                                      req_ready, hit_valid, miss_uuid_valid;
    logic                                      mem_wr_valid, buffer_empty;
    logic [cache_types_pkg::UUID_SIZE-1:0]     miss_uuid;
    logic [cache_types_pkg::BANKS-1:0][cache_types_pkg::UUID_SIZE-1:0] done_uuid;
    logic [cache_types_pkg::BANKS-1:0][cache_types_pkg::ADDR_W-1:0]    mem_rd_addr;

    integer seed = 32'h242b_12ac;
    int     mem_wait [cache_types_pkg::BANKS];  // cycles left before a bank gets its block
    logic   mem_hold     = 1'b0;
    logic   hit_expected = 1'b0;
    logic [31:0] hit_word;
    logic [cache_types_pkg::BANKS-1:0]         valid_next;
    cache_types_pkg::cache_block [cache_types_pkg::BANKS-1:0] data_next;
    logic [cache_types_pkg::TAG_BIT_LEN-1:0]   tag_pool [3] = '{25'h000_0013, 25'h0a5_5a01,
                                                                25'h1ff_fffe};

    nonblocking_cache i_nonblocking_cache (.*);

    `include "tb_cache_model.svh"

    always #5 CLK = ~CLK;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    // 96 addresses: 3 tags, 8 sets, 4 words
    function automatic logic [31:0] pool_addr(input int i);
        return {tag_pool[i / 32], 3'(i / 4 % 8), 2'(i % 4), 2'b00};
    endfunction

    // ********************************************************************
    // backing memory and per-cycle checks
    // ********************************************************************

    // only one bank is answered per cycle, so two fills never meet in the same cycle
    task automatic plan_memory(input logic valid, input logic rw, input logic [31:0] addr);
        logic answered;
        answered = 1'b0;
        for (int b = 0; b < cache_types_pkg::BANKS; b++) begin
            valid_next[b] = 1'b0;
            if (mem_rd_valid[b] || !mem_rd_req[b]) begin
                mem_wait[b] = -1;
            end else if (mem_wait[b] < 0) begin
                mem_wait[b] = $unsigned($random(seed)) % 8;  // 1 to 8 cycles of latency
            end else if (mem_wait[b] > 0) begin
                mem_wait[b] = mem_wait[b] - 1;
            end
            // a store to the block being returned would miss the refilled copy
            if (mem_wait[b] == 0 && !answered && !mem_hold
                && !(valid && rw && block_of(addr) == mem_rd_addr[b])) begin
                valid_next[b] = 1'b1;
                data_next[b]  = model_block(mem_rd_addr[b]);
                answered      = 1'b1;
            end
        end
    endtask

    task automatic check_cycle();
        logic accepted;
        accepted = req_valid && req_ready;
        assert (hit_valid == hit_expected)
            else report_error($sformatf("error: hit_valid is 0x%0h, expected 0x%0h",
                                        hit_valid, hit_expected));
        if (hit_expected) begin
            assert (hit_data == hit_word)
                else report_error($sformatf("error: hit_data is 0x%0h, expected 0x%0h",
                                            hit_data, hit_word));
        end
        hit_expected = accepted && !req_rw && !miss_uuid_valid;
        hit_word     = model_read(req_addr);

        assert (mem_wr_valid == (accepted && req_rw))
            else report_error($sformatf("error: mem_wr_valid is 0x%0h, expected 0x%0h",
                                        mem_wr_valid, accepted && req_rw));
        if (mem_wr_valid) begin
            assert (mem_wr_addr == req_addr)
                else report_error($sformatf("error: mem_wr_addr is 0x%0h, expected 0x%0h",
                                            mem_wr_addr, req_addr));
            assert (mem_wr_data == req_store_value)
                else report_error($sformatf("error: mem_wr_data is 0x%0h, expected 0x%0h",
                                            mem_wr_data, req_store_value));
            model_store(mem_wr_addr, mem_wr_data);
        end

        if (miss_uuid_valid) begin
            assert (accepted)
                else report_error("miss_uuid_valid raised for a request that was not accepted");
            assert (miss_uuid == next_uuid)
                else report_error($sformatf("error: miss_uuid is 0x%0h, expected 0x%0h",
                                            miss_uuid, next_uuid));
            issue_uuid(miss_uuid);
        end
        for (int b = 0; b < cache_types_pkg::BANKS; b++) begin
            if (done_valid[b]) begin
                assert (outstanding[done_uuid[b]])
                    else report_error($sformatf(
                        "error: done_uuid[%0d] is 0x%0h, which is not outstanding",
                        b, done_uuid[b]));
                complete_uuid(done_uuid[b]);
            end
        end
    endtask

    task automatic drive(input logic valid, input logic rw, input logic [31:0] addr,
                         input logic [31:0] data);
        plan_memory(valid, rw, addr);
        @(posedge CLK);
        req_valid       <= valid;
        req_rw          <= rw;
        req_addr        <= addr;
        req_store_value <= data;
        mem_rd_valid    <= valid_next;
        mem_rd_data     <= data_next;
        @(negedge CLK);  // outputs are settled mid-cycle
        check_cycle();
    endtask

    task automatic wait_quiet();
        int quiet;
        int n;
        quiet = 0;
        for (n = 0; n < 400 && quiet < 4; n++) begin
            drive(1'b0, 1'b0, '0, '0);
            if (buffer_empty && mem_rd_req == '0 && done_valid == '0) begin
                quiet = quiet + 1;
            end else begin
                quiet = 0;
            end
        end
        assert (quiet >= 4) else report_error("timeout waiting for the cache to go idle");
    endtask

    // ********************************************************************
    // test sequence
    // ********************************************************************

    initial begin
        int          k;
        int          n;
        logic        stalled;
        logic [31:0] r;
        logic [31:0] data;
        nRST            <= 1'b0;
        req_valid       <= 1'b0;
        req_rw          <= 1'b0;
        req_addr        <= '0;
        req_store_value <= '0;
        mem_rd_valid    <= '0;
        mem_rd_data     <= '0;
        for (int b = 0; b < cache_types_pkg::BANKS; b++) begin
            mem_wait[b] = -1;
        end
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        assert (req_ready && buffer_empty)
            else report_error("req_ready or buffer_empty is low after reset");
        assert (!hit_valid && done_valid == '0 && mem_rd_req == '0)
            else report_error("hit_valid, done_valid or mem_rd_req is high after reset");

        // distinct blocks on bank 0 while memory holds its answers
        mem_hold = 1'b1;
        k        = 0;
        stalled  = 1'b0;
        for (n = 0; n < 40 && !stalled; n++) begin
            drive(1'b1, 1'b0, pool_addr((k / 4) * 32 + (k % 4) * 8), '0);
            if (req_ready) begin
                assert (miss_uuid_valid && miss_uuid == 8'(k))
                    else report_error($sformatf("error: miss_uuid is 0x%0h, expected 0x%0h",
                                                miss_uuid, k));
                k = k + 1;
            end else begin
                stalled = 1'b1;
            end
        end
        assert (stalled) else report_error("req_ready never dropped with memory held");
        assert (k > 4)
            else report_error($sformatf(
                "error: req_ready dropped after 0x%0h misses, expected more than 0x4", k));
        mem_hold = 1'b0;
        wait_quiet();

        for (n = 0; n < 400; n++) begin
            r    = $random(seed);
            data = $random(seed);
            drive(1'b1, r[0], pool_addr($unsigned($random(seed)) % 96), data);
        end
        wait_quiet();

        for (n = 0; n < 96; n++) begin
            read_back(pool_addr(n));
        end
        $display("all tests passed");
        $finish;
    end

endmodule
